/* include/mul16_config.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Width settings for the pipelined 16x16 multiplier
// Include in any file that sizes operands, partial
// products, the product or the lookahead adders
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MUL16_CONFIG_SVH
`define MUL16_CONFIG_SVH

// Operand, byte half and product widths
`define MUL16_OP_W   16
`define MUL16_HALF_W 8
`define MUL16_PROD_W 32
`define MUL16_PP_W   16

// Carry lookahead grouping, groups times width covers the product
`define CLA_GROUP_W  4
`define CLA_GROUPS   8

`endif

/* rtl/mul16_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types shared by the multiplier pipeline stages
// Refer to them as mul16_pkg::name
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mul16_config.svh"

package mul16_pkg;

  // Byte view of one operand
  typedef struct packed {
    logic [`MUL16_HALF_W-1:0] hi;
    logic [`MUL16_HALF_W-1:0] lo;
  } operand_bytes_t;

  // Whole word for checks, bytes for the multipliers
  typedef union packed {
    logic [`MUL16_OP_W-1:0] word;
    operand_bytes_t         bytes;
  } operand_t;

  // One byte-by-byte product
  typedef logic [`MUL16_PP_W-1:0] pp_t;

endpackage

/* rtl/partial_product_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Registered partial products from execute to result
// Products are meaningful whenever valid is high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mul16_config.svh"

interface partial_product_if;

  logic           valid;
  mul16_pkg::pp_t ll;
  mul16_pkg::pp_t lh;
  mul16_pkg::pp_t hl;
  mul16_pkg::pp_t hh;

  modport producer (
    output valid, ll, lh, hl, hh
  );

  modport consumer (
    input valid, ll, lh, hl, hh
  );

endinterface

/* rtl/mul16_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// First pipeline stage, captures both operands
// Operands leave in union form so later stages can
// pick the high and low bytes by name
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mul16_config.svh"

module mul16_decode (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   in_valid,
  input  logic [`MUL16_OP_W-1:0] a,
  input  logic [`MUL16_OP_W-1:0] b,
  output logic                   op_valid,
  output mul16_pkg::operand_t    op_a,
  output mul16_pkg::operand_t    op_b
);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      op_valid <= 1'b0;
    end else begin
      op_valid <= in_valid;
    end
  end

  // Operand words only load on a valid cycle
  always_ff @(posedge clk) begin
    if (in_valid) begin
      op_a.word <= a;
      op_b.word <= b;
    end
  end

  // A pair accepted with in_valid must be fully known once captured
  a_operands_known: assert property (
    @(posedge clk) disable iff (!arst_n)
    in_valid |=> !$isunknown({op_a.word, op_b.word})
  );

endmodule

/* rtl/array_mul8.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Exact unsigned 8x8 array multiplier
// Carry-save rows of full adders, closed by a ripple
// row that forms the upper byte, purely combinational
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mul16_config.svh"

module array_mul8 (
  input  logic [`MUL16_HALF_W-1:0] x,
  input  logic [`MUL16_HALF_W-1:0] y,
  output mul16_pkg::pp_t           p
);

  localparam int H = `MUL16_HALF_W;

  // Row i holds sum and carry vectors after adding x[i] & y
  logic [H-1:0] s_row [H];
  logic [H-2:0] c_row [H];
  logic [H-1:0] rip_c;

  // Returns {carry, sum}
  function automatic logic [1:0] full_add(
    input logic fa_a,
    input logic fa_b,
    input logic fa_c
  );
    full_add = {(fa_a & fa_b) | (fa_b & fa_c) | (fa_a & fa_c), fa_a ^ fa_b ^ fa_c};
  endfunction

  always_comb begin
    for (int j = 0; j < H; j++) begin
      s_row[0][j] = x[0] & y[j];
    end
    c_row[0] = '0;
    for (int i = 1; i < H; i++) begin
      for (int j = 0; j < H - 1; j++) begin
        {c_row[i][j], s_row[i][j]} = full_add(s_row[i-1][j+1], c_row[i-1][j], x[i] & y[j]);
      end
      // Top bit of each row has nothing to add yet
      s_row[i][H-1] = x[i] & y[H-1];
    end
  end

  // Ripple merge of the last sum and carry rows
  always_comb begin
    rip_c[0] = 1'b0;
    for (int j = 0; j < H - 1; j++) begin
      {rip_c[j+1], p[H+j]} = full_add(s_row[H-1][j+1], c_row[H-1][j], rip_c[j]);
    end
    for (int i = 0; i < H; i++) begin
      p[i] = s_row[i][0];
    end
    p[2*H-1] = rip_c[H-1];
  end

endmodule

/* rtl/mul16_execute.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Second pipeline stage
// Four byte-by-byte products are formed and held in
// the partial product interface for the result stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mul16_config.svh"

module mul16_execute (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                op_valid,
  input  mul16_pkg::operand_t op_a,
  input  mul16_pkg::operand_t op_b,
  partial_product_if.producer pp
);

  // Largest product of two bytes, 255 * 255
  localparam int unsigned PP_MAX = (2 ** `MUL16_HALF_W - 1) * (2 ** `MUL16_HALF_W - 1);

  mul16_pkg::pp_t ll_c;
  mul16_pkg::pp_t lh_c;
  mul16_pkg::pp_t hl_c;
  mul16_pkg::pp_t hh_c;

  array_mul8 u_mul_ll (
    .x (op_a.bytes.lo),
    .y (op_b.bytes.lo),
    .p (ll_c)
  );

  array_mul8 u_mul_lh (
    .x (op_a.bytes.lo),
    .y (op_b.bytes.hi),
    .p (lh_c)
  );

  array_mul8 u_mul_hl (
    .x (op_a.bytes.hi),
    .y (op_b.bytes.lo),
    .p (hl_c)
  );

  array_mul8 u_mul_hh (
    .x (op_a.bytes.hi),
    .y (op_b.bytes.hi),
    .p (hh_c)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pp.valid <= 1'b0;
    end else begin
      pp.valid <= op_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (op_valid) begin
      pp.ll <= ll_c;
      pp.lh <= lh_c;
      pp.hl <= hl_c;
      pp.hh <= hh_c;
    end
  end

  a_pp_in_range: assert property (
    @(posedge clk) disable iff (!arst_n)
    pp.valid |-> (pp.ll <= PP_MAX) && (pp.lh <= PP_MAX) &&
                 (pp.hl <= PP_MAX) && (pp.hh <= PP_MAX)
  );

endmodule

/* rtl/cla_adder32.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32-bit carry-lookahead adder, no carry in or out
// Eight 4-bit groups feed a second lookahead level
// that supplies every group's carry in parallel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mul16_config.svh"

module cla_adder32 (
  input  logic [`MUL16_PROD_W-1:0] a,
  input  logic [`MUL16_PROD_W-1:0] b,
  output logic [`MUL16_PROD_W-1:0] sum
);

  localparam int W = `CLA_GROUP_W;
  localparam int N = `CLA_GROUPS;

  logic [`MUL16_PROD_W-1:0] p;
  logic [`MUL16_PROD_W-1:0] g;
  logic [`MUL16_PROD_W-1:0] c;
  logic [N-1:0]             p_ext [N];
  logic [N-1:0]             g_ext [N];
  logic [N-1:0]             grp_p;
  logic [N-1:0]             grp_g;
  logic [N-1:0]             grp_c;

  // Carry into position idx as a flat sum of products
  function automatic logic look_carry(
    input logic [N-1:0] gen,
    input logic [N-1:0] prop,
    input logic         cin,
    input int           idx
  );
    logic carry;
    logic term;
    carry = 1'b0;
    for (int j = 0; j < N; j++) begin
      if (j < idx) begin
        term = gen[j];
        for (int m = 0; m < N; m++) begin
          if (m > j && m < idx) begin
            term = term & prop[m];
          end
        end
        carry = carry | term;
      end
    end
    term = cin;
    for (int m = 0; m < N; m++) begin
      if (m < idx) begin
        term = term & prop[m];
      end
    end
    return carry | term;
  endfunction

  assign p = a ^ b;
  assign g = a & b;

  // Group propagate and generate
  always_comb begin
    for (int k = 0; k < N; k++) begin
      p_ext[k]        = '0;
      g_ext[k]        = '0;
      p_ext[k][W-1:0] = p[k*W +: W];
      g_ext[k][W-1:0] = g[k*W +: W];
      grp_p[k]        = &p[k*W +: W];
      grp_g[k]        = look_carry(g_ext[k], p_ext[k], 1'b0, W);
    end
  end

  // Second level, all group carries at once
  always_comb begin
    for (int k = 0; k < N; k++) begin
      grp_c[k] = look_carry(grp_g, grp_p, 1'b0, k);
    end
  end

  always_comb begin
    for (int k = 0; k < N; k++) begin
      for (int i = 0; i < W; i++) begin
        c[k*W+i] = look_carry(g_ext[k], p_ext[k], grp_c[k], i);
      end
    end
  end

  assign sum = p ^ c;

endmodule

/* rtl/mul16_result.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Third pipeline stage
// Aligns the four partial products, sums them with
// two chained lookahead adders, registers the product
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mul16_config.svh"

module mul16_result (
  input  logic                     clk,
  input  logic                     arst_n,
  partial_product_if.consumer      pp,
  output logic                     out_valid,
  output logic [`MUL16_PROD_W-1:0] product
);

  logic [`MUL16_PROD_W-1:0] llhh_w;
  logic [`MUL16_PROD_W-1:0] lh_w;
  logic [`MUL16_PROD_W-1:0] hl_w;
  logic [`MUL16_PROD_W-1:0] part_sum;
  logic [`MUL16_PROD_W-1:0] full_sum;

  // hh and ll never overlap, so they share one word
  assign llhh_w = {pp.hh, pp.ll};
  assign lh_w   = {{`MUL16_HALF_W{1'b0}}, pp.lh, {`MUL16_HALF_W{1'b0}}};
  assign hl_w   = {{`MUL16_HALF_W{1'b0}}, pp.hl, {`MUL16_HALF_W{1'b0}}};

  cla_adder32 u_add_lh (
    .a   (llhh_w),
    .b   (lh_w),
    .sum (part_sum)
  );

  cla_adder32 u_add_hl (
    .a   (part_sum),
    .b   (hl_w),
    .sum (full_sum)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= pp.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (pp.valid) begin
      product <= full_sum;
    end
  end

  a_sum_exact: assert property (
    @(posedge clk) disable iff (!arst_n)
    pp.valid |=> product == $past(llhh_w + lh_w + hl_w)
  );

endmodule

/* rtl/mul16_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pipelined 16x16 unsigned multiplier, top level
// A pair given with in_valid returns its product with
// out_valid three cycles later, one pair per cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mul16_config.svh"

module mul16_top (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     in_valid,
  input  logic [`MUL16_OP_W-1:0]   a,
  input  logic [`MUL16_OP_W-1:0]   b,
  output logic                     out_valid,
  output logic [`MUL16_PROD_W-1:0] product
);

  logic                op_valid;
  mul16_pkg::operand_t op_a;
  mul16_pkg::operand_t op_b;

  partial_product_if pp_if ();

  mul16_decode u_decode (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .a        (a),
    .b        (b),
    .op_valid (op_valid),
    .op_a     (op_a),
    .op_b     (op_b)
  );

  mul16_execute u_execute (
    .clk      (clk),
    .arst_n   (arst_n),
    .op_valid (op_valid),
    .op_a     (op_a),
    .op_b     (op_b),
    .pp       (pp_if.producer)
  );

  mul16_result u_result (
    .clk       (clk),
    .arst_n    (arst_n),
    .pp        (pp_if.consumer),
    .out_valid (out_valid),
    .product   (product)
  );

endmodule

/* verif/mul16_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Self-checking testbench for the pipelined 16x16
// multiplier. Drives corner, carry pattern, streamed
// and gapped random pairs, while concurrent assertions
// check products, ordering and the 3-cycle latency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mul16_config.svh"

module mul16_tb;

  localparam int CLK_HALF    = 2;
  localparam int RST_CYCLES  = 5;
  localparam int DRAIN_LIMIT = 20;
  localparam int RUN_LIMIT   = 5000;
  localparam int STREAM_LEN  = 200;
  localparam int GAP_LEN     = 300;

  logic                     clk;
  logic                     arst_n;
  logic                     in_valid;
  logic [`MUL16_OP_W-1:0]   a;
  logic [`MUL16_OP_W-1:0]   b;
  logic                     out_valid;
  logic [`MUL16_PROD_W-1:0] product;

  // Reference model state
  logic [`MUL16_PROD_W-1:0] exp_q [$];
  logic [`MUL16_PROD_W-1:0] exp_product = '0;
  logic                     exp_avail = 1'b0;
  logic [2:0]               in_valid_dly = '0;
  logic                     seen_input = 1'b0;

  mul16_top u_mul16_top (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .a         (a),
    .b         (b),
    .out_valid (out_valid),
    .product   (product)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  // Random operand from the low bits of one draw
  function automatic logic [`MUL16_OP_W-1:0] rand_operand();
    logic [31:0] r;
    r = $urandom;
    return r[`MUL16_OP_W-1:0];
  endfunction

  // One operand pair on the next falling edge, expected product queued
  task automatic apply_pair(input logic [`MUL16_OP_W-1:0] x, input logic [`MUL16_OP_W-1:0] y);
    @(negedge clk);
    in_valid = 1'b1;
    a        = x;
    b        = y;
    exp_q.push_back({{`MUL16_OP_W{1'b0}}, x} * {{`MUL16_OP_W{1'b0}}, y});
  endtask

  // Idle cycle, operands carry junk that must be ignored
  task automatic apply_idle();
    @(negedge clk);
    in_valid = 1'b0;
    a        = rand_operand();
    b        = rand_operand();
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while (exp_q.size() != 0) begin
      if (cnt >= DRAIN_LIMIT) begin
        stop_run("timed out waiting for all queued products to come out");
      end else begin
        cnt++;
        apply_idle();
      end
    end
  endtask

  // Input history for the fixed latency check
  always @(posedge clk) begin
    in_valid_dly <= {in_valid_dly[1:0], in_valid};
    if (in_valid) begin
      seen_input <= 1'b1;
    end
  end

  // Outputs are stable here, so the next expected value is staged
  always @(negedge clk) begin
    if (arst_n && out_valid) begin
      exp_avail = exp_q.size() > 0;
      if (exp_avail) begin
        exp_product = exp_q.pop_front();
      end
    end
  end

  a_idle_until_input: assert property (
    @(posedge clk) !seen_input |-> !out_valid
  ) else stop_run($sformatf("error at %0t ns: out_valid expected 0 actual %0b",
                            $time, $sampled(out_valid)));

  a_latency: assert property (
    @(posedge clk) disable iff (!arst_n)
    out_valid == in_valid_dly[2]
  ) else stop_run($sformatf("error at %0t ns: out_valid expected %0b actual %0b",
                            $time, $sampled(in_valid_dly[2]), $sampled(out_valid)));

  a_no_extra_result: assert property (
    @(posedge clk) disable iff (!arst_n)
    out_valid |-> exp_avail
  ) else stop_run("out_valid was high with no operand pair left to answer");

  a_product: assert property (
    @(posedge clk) disable iff (!arst_n)
    out_valid && exp_avail |-> product == exp_product
  ) else stop_run($sformatf("error at %0t ns: product expected 0x%08h actual 0x%08h",
                            $time, $sampled(exp_product), $sampled(product)));

  initial begin
    int i;
    void'($urandom(32'h0a5a_ebb4));
    arst_n   = 1'b0;
    in_valid = 1'b0;
    a        = '0;
    b        = '0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    repeat (3) apply_idle();

    // Corners
    apply_pair(16'h0000, rand_operand());
    apply_pair(rand_operand(), 16'h0000);
    apply_pair(16'h0001, 16'hbeef);
    apply_pair(16'h1234, 16'h0001);
    apply_pair(16'hffff, 16'hffff);
    apply_pair(16'h0000, 16'h0000);

    // Carries across lookahead groups in both adders
    apply_pair(16'h00ff, 16'h00ff);
    apply_pair(16'hff00, 16'h00ff);
    apply_pair(16'h00ff, 16'hff00);
    apply_pair(16'h8080, 16'h8080);
    wait_drain();

    // Back-to-back stream
    for (i = 0; i < STREAM_LEN; i++) begin
      apply_pair(rand_operand(), rand_operand());
    end
    wait_drain();

    // Random idle gaps
    for (i = 0; i < GAP_LEN; i++) begin
      if ($urandom_range(0, 99) < 60) begin
        apply_pair(rand_operand(), rand_operand());
      end else begin
        apply_idle();
      end
    end
    wait_drain();
    repeat (6) apply_idle();

    $display("Verification passed");
    $finish;
  end

  // Run limit for the whole simulation
  initial begin
    repeat (RUN_LIMIT) @(posedge clk);
    stop_run("simulation ran past its cycle limit without finishing");
  end

endmodule

/* verilog.f */
+incdir+include
rtl/mul16_pkg.sv
rtl/partial_product_if.sv
rtl/mul16_decode.sv
rtl/array_mul8.sv
rtl/mul16_execute.sv
rtl/cla_adder32.sv
rtl/mul16_result.sv
rtl/mul16_top.sv
verif/mul16_tb.sv

/* Bender.yml */
package:
  name: mul16

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/mul16_pkg.sv
      - rtl/partial_product_if.sv
      - rtl/mul16_decode.sv
      - rtl/array_mul8.sv
      - rtl/mul16_execute.sv
      - rtl/cla_adder32.sv
      - rtl/mul16_result.sv
      - rtl/mul16_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/mul16_tb.sv
